//--- build.f
+incdir+tb
src/core_pkg.sv
src/if_stage.sv
src/id_stage.sv
src/ex_stage.sv
src/ex_mem.sv
src/mem_wb_stage.sv
src/core_top.sv
tb/tb_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_core -Mdir obj_dir
./obj_dir/Vtb_core | tee sim.log

if grep -q "^TEST OK$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- src/core_pkg.sv
package core_pkg;

  localparam int XLEN     = 32;
  localparam int INST_LEN = 32;

  // ####################
  // Major opcodes
  // ####################
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ####################
  // Execute controls
  // ####################
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

  localparam logic [11:0] CSR_MSCRATCH = 12'h340; // Only CSR implemented.

endpackage

//--- src/core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter logic [core_pkg::XLEN-1:0] RESET_PC   = '0,
  parameter int                        DMEM_DEPTH = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  output logic [core_pkg::XLEN-1:0]     imem_addr_o,
  input  logic [core_pkg::INST_LEN-1:0] imem_data_i,
  output logic                          wb_valid_o,
  output logic [4:0]                    wb_rd_o,
  output logic [core_pkg::XLEN-1:0]     wb_data_o
);
  import core_pkg::*;

  // ####################
  // IF to ID
  // ####################
  logic [XLEN-1:0]     if_pc;
  logic [INST_LEN-1:0] if_inst;
  logic                if_valid;

  // ####################
  // ID to EX
  // ####################
  logic [XLEN-1:0]     id_pc;
  logic [INST_LEN-1:0] id_inst;
  logic [4:0]          id_rs1;
  logic [4:0]          id_rs2;
  logic [XLEN-1:0]     id_rs1_data;
  logic [XLEN-1:0]     id_rs2_data;
  logic [XLEN-1:0]     id_imm;
  logic                id_use_imm;
  alu_op_e             id_alu_op;
  csr_op_e             id_csr_op;
  logic [4:0]          id_rd;
  logic                id_reg_write;
  logic                id_mem_read;
  logic                id_mem_write;
  logic                id_valid;

  // ####################
  // EX and MEM
  // ####################
  logic [XLEN-1:0]     ex_pc;
  logic [INST_LEN-1:0] ex_inst;
  logic [XLEN-1:0]     ex_alu_data;
  logic [XLEN-1:0]     ex_csr_data;
  logic                ex_csr_valid;
  logic [XLEN-1:0]     ex_store_data;
  logic [4:0]          ex_rd;
  logic                ex_reg_write;
  logic                ex_mem_read;
  logic                ex_mem_write;
  logic                ex_valid;
  logic [INST_LEN-1:0] mem_inst;
  logic [XLEN-1:0]     mem_alu_data;
  logic [XLEN-1:0]     mem_csr_data;
  logic                mem_csr_valid;
  logic [XLEN-1:0]     mem_store_data;
  logic [4:0]          mem_rd;
  logic                mem_reg_write;
  logic                mem_mem_read;
  logic                mem_mem_write;
  logic                mem_valid;
  logic [XLEN-1:0]     csr_q;

  if_stage #(
    .RESET_PC(RESET_PC)
  ) u_if_stage (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .imem_addr_o(imem_addr_o),
    .imem_data_i(imem_data_i),
    .pc_o       (if_pc),
    .inst_o     (if_inst),
    .valid_o    (if_valid)
  );

  id_stage u_id_stage (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .pc_i       (if_pc),
    .inst_i     (if_inst),
    .valid_i    (if_valid),
    .wb_we_i    (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .wb_data_i  (wb_data_o),
    .pc_o       (id_pc),
    .inst_o     (id_inst),
    .rs1_o      (id_rs1),
    .rs2_o      (id_rs2),
    .rs1_data_o (id_rs1_data),
    .rs2_data_o (id_rs2_data),
    .imm_o      (id_imm),
    .use_imm_o  (id_use_imm),
    .alu_op_o   (id_alu_op),
    .csr_op_o   (id_csr_op),
    .rd_o       (id_rd),
    .reg_write_o(id_reg_write),
    .mem_read_o (id_mem_read),
    .mem_write_o(id_mem_write),
    .valid_o    (id_valid)
  );

  ex_stage u_ex_stage (
    .pc_i           (id_pc),
    .inst_i         (id_inst),
    .rs1_i          (id_rs1),
    .rs2_i          (id_rs2),
    .rs1_data_i     (id_rs1_data),
    .rs2_data_i     (id_rs2_data),
    .imm_i          (id_imm),
    .use_imm_i      (id_use_imm),
    .alu_op_i       (id_alu_op),
    .csr_op_i       (id_csr_op),
    .rd_i           (id_rd),
    .reg_write_i    (id_reg_write),
    .mem_read_i     (id_mem_read),
    .mem_write_i    (id_mem_write),
    .valid_i        (id_valid),
    .fwd_mem_rd_i   (mem_rd),
    .fwd_mem_we_i   (mem_reg_write),
    .fwd_mem_data_i (mem_alu_data),
    .fwd_wb_rd_i    (wb_rd_o),
    .fwd_wb_we_i    (wb_valid_o),
    .fwd_wb_data_i  (wb_data_o),
    .csr_q_i        (csr_q),
    .csr_fwd_valid_i(mem_csr_valid),
    .csr_fwd_data_i (mem_csr_data),
    .pc_o           (ex_pc),
    .inst_o         (ex_inst),
    .alu_data_o     (ex_alu_data),
    .csr_data_o     (ex_csr_data),
    .csr_valid_o    (ex_csr_valid),
    .store_data_o   (ex_store_data),
    .rd_o           (ex_rd),
    .reg_write_o    (ex_reg_write),
    .mem_read_o     (ex_mem_read),
    .mem_write_o    (ex_mem_write),
    .valid_o        (ex_valid)
  );

  ex_mem u_ex_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .pc_i        (ex_pc),
    .inst_i      (ex_inst),
    .alu_data_i  (ex_alu_data),
    .csr_data_i  (ex_csr_data),
    .csr_valid_i (ex_csr_valid),
    .store_data_i(ex_store_data),
    .rd_i        (ex_rd),
    .reg_write_i (ex_reg_write),
    .mem_read_i  (ex_mem_read),
    .mem_write_i (ex_mem_write),
    .valid_i     (ex_valid),
    .pc_o        (),
    .inst_o      (mem_inst),
    .alu_data_o  (mem_alu_data),
    .csr_data_o  (mem_csr_data),
    .csr_valid_o (mem_csr_valid),
    .store_data_o(mem_store_data),
    .rd_o        (mem_rd),
    .reg_write_o (mem_reg_write),
    .mem_read_o  (mem_mem_read),
    .mem_write_o (mem_mem_write),
    .valid_o     (mem_valid)
  );

  mem_wb_stage #(
    .DMEM_DEPTH(DMEM_DEPTH)
  ) u_mem_wb_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .inst_i      (mem_inst),
    .alu_data_i  (mem_alu_data),
    .csr_data_i  (mem_csr_data),
    .csr_valid_i (mem_csr_valid),
    .store_data_i(mem_store_data),
    .rd_i        (mem_rd),
    .reg_write_i (mem_reg_write),
    .mem_read_i  (mem_mem_read),
    .mem_write_i (mem_mem_write),
    .valid_i     (mem_valid),
    .csr_q_o     (csr_q),
    .wb_we_o     (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o)
  );

endmodule

//--- src/ex_mem.sv
`timescale 1ns/1ps

module ex_mem (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [core_pkg::XLEN-1:0]     pc_i,
  input  logic [core_pkg::INST_LEN-1:0] inst_i,
  input  logic [core_pkg::XLEN-1:0]     alu_data_i,
  input  logic [core_pkg::XLEN-1:0]     csr_data_i,
  input  logic                          csr_valid_i,
  input  logic [core_pkg::XLEN-1:0]     store_data_i,
  input  logic [4:0]                    rd_i,
  input  logic                          reg_write_i,
  input  logic                          mem_read_i,
  input  logic                          mem_write_i,
  input  logic                          valid_i,
  output logic [core_pkg::XLEN-1:0]     pc_o,
  output logic [core_pkg::INST_LEN-1:0] inst_o,
  output logic [core_pkg::XLEN-1:0]     alu_data_o,
  output logic [core_pkg::XLEN-1:0]     csr_data_o,
  output logic                          csr_valid_o,
  output logic [core_pkg::XLEN-1:0]     store_data_o,
  output logic [4:0]                    rd_o,
  output logic                          reg_write_o,
  output logic                          mem_read_o,
  output logic                          mem_write_o,
  output logic                          valid_o
);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o         <= '0;
      inst_o       <= '0;
      alu_data_o   <= '0;
      csr_data_o   <= '0;
      csr_valid_o  <= 1'b0;
      store_data_o <= '0;
      rd_o         <= '0;
      reg_write_o  <= 1'b0;
      mem_read_o   <= 1'b0;
      mem_write_o  <= 1'b0;
      valid_o      <= 1'b0;
    end else begin
      pc_o         <= pc_i;
      inst_o       <= inst_i;
      alu_data_o   <= alu_data_i;
      csr_data_o   <= csr_data_i;
      csr_valid_o  <= csr_valid_i && valid_i; // Bubbles never commit.
      store_data_o <= store_data_i;
      rd_o         <= rd_i;
      reg_write_o  <= reg_write_i && valid_i;
      mem_read_o   <= mem_read_i;
      mem_write_o  <= mem_write_i && valid_i;
      valid_o      <= valid_i;
    end
  end

endmodule

//--- src/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
  input  logic [core_pkg::XLEN-1:0]     pc_i,
  input  logic [core_pkg::INST_LEN-1:0] inst_i,
  input  logic [4:0]                    rs1_i,
  input  logic [4:0]                    rs2_i,
  input  logic [core_pkg::XLEN-1:0]     rs1_data_i,
  input  logic [core_pkg::XLEN-1:0]     rs2_data_i,
  input  logic [core_pkg::XLEN-1:0]     imm_i,
  input  logic                          use_imm_i,
  input  core_pkg::alu_op_e             alu_op_i,
  input  core_pkg::csr_op_e             csr_op_i,
  input  logic [4:0]                    rd_i,
  input  logic                          reg_write_i,
  input  logic                          mem_read_i,
  input  logic                          mem_write_i,
  input  logic                          valid_i,
  input  logic [4:0]                    fwd_mem_rd_i,
  input  logic                          fwd_mem_we_i,
  input  logic [core_pkg::XLEN-1:0]     fwd_mem_data_i,
  input  logic [4:0]                    fwd_wb_rd_i,
  input  logic                          fwd_wb_we_i,
  input  logic [core_pkg::XLEN-1:0]     fwd_wb_data_i,
  input  logic [core_pkg::XLEN-1:0]     csr_q_i,
  input  logic                          csr_fwd_valid_i,
  input  logic [core_pkg::XLEN-1:0]     csr_fwd_data_i,
  output logic [core_pkg::XLEN-1:0]     pc_o,
  output logic [core_pkg::INST_LEN-1:0] inst_o,
  output logic [core_pkg::XLEN-1:0]     alu_data_o,
  output logic [core_pkg::XLEN-1:0]     csr_data_o,
  output logic                          csr_valid_o,
  output logic [core_pkg::XLEN-1:0]     store_data_o,
  output logic [4:0]                    rd_o,
  output logic                          reg_write_o,
  output logic                          mem_read_o,
  output logic                          mem_write_o,
  output logic                          valid_o
);
  import core_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] csr_cur;

  function automatic logic [XLEN-1:0] fwd_sel(input logic [4:0] rs,
                                              input logic [XLEN-1:0] rf_data);
    if (rs == 5'd0) return '0;
    if (fwd_mem_we_i && fwd_mem_rd_i == rs) return fwd_mem_data_i; // Youngest wins.
    if (fwd_wb_we_i && fwd_wb_rd_i == rs) return fwd_wb_data_i;
    return rf_data;
  endfunction

  always_comb begin
    op_a = fwd_sel(rs1_i, rs1_data_i);
    op_b = fwd_sel(rs2_i, rs2_data_i);
  end

  assign alu_b = use_imm_i ? imm_i : op_b;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    alu_res = op_a + alu_b; // Also lw/sw address.
      ALU_SUB:    alu_res = op_a - alu_b;
      ALU_AND:    alu_res = op_a & alu_b;
      ALU_OR:     alu_res = op_a | alu_b;
      ALU_XOR:    alu_res = op_a ^ alu_b;
      ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(alu_b)};
      ALU_SLTU:   alu_res = {31'b0, op_a < alu_b};
      ALU_SLL:    alu_res = op_a << alu_b[4:0];
      ALU_SRL:    alu_res = op_a >> alu_b[4:0];
      ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> alu_b[4:0]);
      ALU_PASS_B: alu_res = alu_b;
      default:    alu_res = '0;
    endcase
  end

  // mscratch in MEM has not committed yet, so take it from there.
  assign csr_cur = csr_fwd_valid_i ? csr_fwd_data_i : csr_q_i;

  always_comb begin
    case (csr_op_i)
      CSR_RW:  csr_data_o = op_a;
      CSR_RS:  csr_data_o = csr_cur | op_a;
      CSR_RC:  csr_data_o = csr_cur & ~op_a;
      default: csr_data_o = csr_cur;
    endcase
  end

  assign csr_valid_o  = (csr_op_i != CSR_NONE);
  assign alu_data_o   = csr_valid_o ? csr_cur : alu_res; // rd gets old CSR.
  assign store_data_o = op_b;
  assign pc_o         = pc_i;
  assign inst_o       = inst_i;
  assign rd_o         = rd_i;
  assign reg_write_o  = reg_write_i;
  assign mem_read_o   = mem_read_i;
  assign mem_write_o  = mem_write_i;
  assign valid_o      = valid_i;

endmodule

//--- src/id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [core_pkg::XLEN-1:0]     pc_i,
  input  logic [core_pkg::INST_LEN-1:0] inst_i,
  input  logic                          valid_i,
  input  logic                          wb_we_i,
  input  logic [4:0]                    wb_rd_i,
  input  logic [core_pkg::XLEN-1:0]     wb_data_i,
  output logic [core_pkg::XLEN-1:0]     pc_o,
  output logic [core_pkg::INST_LEN-1:0] inst_o,
  output logic [4:0]                    rs1_o,
  output logic [4:0]                    rs2_o,
  output logic [core_pkg::XLEN-1:0]     rs1_data_o,
  output logic [core_pkg::XLEN-1:0]     rs2_data_o,
  output logic [core_pkg::XLEN-1:0]     imm_o,
  output logic                          use_imm_o,
  output core_pkg::alu_op_e             alu_op_o,
  output core_pkg::csr_op_e             csr_op_o,
  output logic [4:0]                    rd_o,
  output logic                          reg_write_o,
  output logic                          mem_read_o,
  output logic                          mem_write_o,
  output logic                          valid_o
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [1:31];
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            use_imm;
  logic            reg_write;
  logic            mem_read;
  logic            mem_write;
  alu_op_e         alu_op;
  csr_op_e         csr_op;

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] rf_read(input logic [4:0] addr);
    if (addr == 5'd0) return '0;
    if (wb_we_i && wb_rd_i == addr) return wb_data_i; // Write-through.
    return regs[addr];
  endfunction

  // ####################
  // Register file
  // ####################
  always_ff @(posedge clk_i) begin
    if (wb_we_i && wb_rd_i != 5'd0) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  always_comb begin
    rs1_data = rf_read(inst_i[19:15]);
    rs2_data = rf_read(inst_i[24:20]);
  end

  // ####################
  // Decoder
  // ####################
  assign opcode     = opcode_e'(inst_i[6:0]);
  assign funct3     = inst_i[14:12];
  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};

  always_comb begin
    imm       = '0;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    alu_op    = ALU_ADD;
    csr_op    = CSR_NONE;
    case (opcode)
      OPC_OP: begin
        reg_write = 1'b1;
        alu_op    = alu_sel(funct3, inst_i[30]);
      end
      OPC_OP_IMM: begin
        imm       = imm_i_type;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        alu_op    = alu_sel(funct3, inst_i[30] && funct3 == 3'b101); // No subi.
      end
      OPC_LUI: begin
        imm       = {inst_i[31:12], 12'b0};
        use_imm   = 1'b1;
        reg_write = 1'b1;
        alu_op    = ALU_PASS_B;
      end
      OPC_LOAD: begin
        imm       = imm_i_type;
        use_imm   = 1'b1;
        reg_write = (funct3 == 3'b010); // lw only.
        mem_read  = (funct3 == 3'b010);
      end
      OPC_STORE: begin
        imm       = imm_s_type;
        use_imm   = 1'b1;
        mem_write = (funct3 == 3'b010); // sw only.
      end
      OPC_SYSTEM: begin
        if (inst_i[31:20] == CSR_MSCRATCH && funct3[1:0] != 2'b00 && !funct3[2]) begin
          reg_write = 1'b1;
          csr_op    = csr_op_e'(funct3[1:0]);
        end
      end
      default: ;
    endcase
    if (!valid_i) begin
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      csr_op    = CSR_NONE;
    end
  end

  // ID/EX register.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o        <= '0;
      inst_o      <= '0;
      rs1_o       <= '0;
      rs2_o       <= '0;
      rs1_data_o  <= '0;
      rs2_data_o  <= '0;
      imm_o       <= '0;
      use_imm_o   <= 1'b0;
      alu_op_o    <= ALU_ADD;
      csr_op_o    <= CSR_NONE;
      rd_o        <= '0;
      reg_write_o <= 1'b0;
      mem_read_o  <= 1'b0;
      mem_write_o <= 1'b0;
      valid_o     <= 1'b0;
    end else begin
      pc_o        <= pc_i;
      inst_o      <= inst_i;
      rs1_o       <= inst_i[19:15];
      rs2_o       <= inst_i[24:20];
      rs1_data_o  <= rs1_data;
      rs2_data_o  <= rs2_data;
      imm_o       <= imm;
      use_imm_o   <= use_imm;
      alu_op_o    <= alu_op;
      csr_op_o    <= csr_op;
      rd_o        <= inst_i[11:7];
      reg_write_o <= reg_write;
      mem_read_o  <= mem_read;
      mem_write_o <= mem_write;
      valid_o     <= valid_i;
    end
  end

endmodule

//--- src/if_stage.sv
`timescale 1ns/1ps

module if_stage #(
  parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  output logic [core_pkg::XLEN-1:0]     imem_addr_o,
  input  logic [core_pkg::INST_LEN-1:0] imem_data_i,
  output logic [core_pkg::XLEN-1:0]     pc_o,
  output logic [core_pkg::INST_LEN-1:0] inst_o,
  output logic                          valid_o
);
  import core_pkg::*;

  logic [XLEN-1:0] pc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_q + XLEN'(4); // No branches, so always sequential.
    end
  end

  assign imem_addr_o = pc_q;

  // IF/ID register.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o    <= '0;
      inst_o  <= '0;
      valid_o <= 1'b0;
    end else begin
      pc_o    <= pc_q;
      inst_o  <= imem_data_i;
      valid_o <= 1'b1;
    end
  end

endmodule

//--- src/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [core_pkg::INST_LEN-1:0] inst_i,
  input  logic [core_pkg::XLEN-1:0]     alu_data_i,
  input  logic [core_pkg::XLEN-1:0]     csr_data_i,
  input  logic                          csr_valid_i,
  input  logic [core_pkg::XLEN-1:0]     store_data_i,
  input  logic [4:0]                    rd_i,
  input  logic                          reg_write_i,
  input  logic                          mem_read_i,
  input  logic                          mem_write_i,
  input  logic                          valid_i,
  output logic [core_pkg::XLEN-1:0]     csr_q_o,
  output logic                          wb_we_o,
  output logic [4:0]                    wb_rd_o,
  output logic [core_pkg::XLEN-1:0]     wb_data_o
);
  import core_pkg::*;

  localparam int AW = $clog2(DMEM_DEPTH);

  logic [XLEN-1:0] dmem [DMEM_DEPTH];
  logic [AW-1:0]   idx;

  assign idx = AW'(alu_data_i[XLEN-1:2] % DMEM_DEPTH); // Word index, wraps.

  always_ff @(posedge clk_i) begin
    if (mem_write_i) begin
      dmem[idx] <= store_data_i;
    end
  end

  // mscratch.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      csr_q_o <= '0;
    end else if (csr_valid_i && inst_i[31:20] == CSR_MSCRATCH) begin
      csr_q_o <= csr_data_i;
    end
  end

  // MEM/WB register.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_we_o   <= 1'b0;
      wb_rd_o   <= '0;
      wb_data_o <= '0;
    end else begin
      wb_we_o   <= reg_write_i && valid_i && rd_i != 5'd0; // x0 is never reported.
      wb_rd_o   <= rd_i;
      wb_data_o <= mem_read_i ? dmem[idx] : alu_data_i;
    end
  end

endmodule

//--- tb/tb_core_prog.svh
`ifndef TB_CORE_PROG_SVH
`define TB_CORE_PROG_SVH

function automatic logic [31:0] sign_extend(input logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

// RV32I result for a funct3 and the funct7 bit 30.
function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
  logic [4:0]  sh;
  logic [31:0] fill;
  sh   = b[4:0];
  fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0; // Sign bits for sra.
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << sh;
    3'b010:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? ((a >> sh) | fill) : (a >> sh);
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

task automatic add_entry(input logic [31:0] inst, input logic [4:0] rd,
                         input logic [31:0] val);
  prog_inst[prog_len[5:0]] = inst;
  prog_rd[prog_len[5:0]]   = rd;
  prog_val[prog_len[5:0]]  = (rd == 5'd0) ? 32'h0 : val;
  if (rd != 5'd0) begin
    xr[rd] = val;
  end
  prog_len = prog_len + 1;
endtask

task automatic imm_op(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [11:0] imm);
  logic alt;
  alt = (f3 == 3'b101) && imm[10]; // srai only.
  add_entry({imm, rs1, f3, rd, 7'b0010011}, rd,
            alu_result(f3, alt, xr[rs1], sign_extend(imm)));
endtask

task automatic reg_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                      input logic [4:0] rs1, input logic [4:0] rs2);
  add_entry({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011}, rd,
            alu_result(f3, alt, xr[rs1], xr[rs2]));
endtask

task automatic upper_imm(input logic [4:0] rd, input logic [19:0] upper);
  add_entry({upper, rd, 7'b0110111}, rd, {upper, 12'h000});
endtask

task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] off);
  logic [31:0] addr;
  addr = xr[rs1] + sign_extend(off);
  dmem_ref[addr[7:2]] = xr[rs2]; // Word index modulo 64.
  add_entry({off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011}, 5'd0, 32'h0);
endtask

task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] off);
  logic [31:0] addr;
  addr = xr[rs1] + sign_extend(off);
  add_entry({off, rs1, 3'b010, rd, 7'b0000011}, rd, dmem_ref[addr[7:2]]);
endtask

task automatic csr_access(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1);
  logic [31:0] old;
  old = mscratch_ref;
  case (f3)
    3'b001:  mscratch_ref = xr[rs1];
    3'b010:  mscratch_ref = old | xr[rs1];
    default: mscratch_ref = old & ~xr[rs1];
  endcase
  add_entry({12'h340, rs1, f3, rd, 7'b1110011}, rd, old); // rd gets the old value.
endtask

task automatic build_program();
  logic [31:0] rnd;
  logic [11:0] ia;
  logic [11:0] ib;
  logic [11:0] ic;
  prog_len     = 0;
  mscratch_ref = 32'h0;
  seed         = 32'hac7;
  for (int r = 0; r < 32; r++) begin
    xr[r[4:0]] = 32'h0;
  end
  rnd = $random(seed);
  ia  = {1'b0, rnd[10:0]}; // Positive.
  rnd = $random(seed);
  ib  = {1'b1, rnd[10:0]}; // Negative.
  rnd = $random(seed);
  ic  = rnd[11:0];

  // ####################
  // Immediates and lui
  // ####################
  imm_op(3'b000, 5'd1, 5'd0, ia);
  imm_op(3'b000, 5'd2, 5'd0, ib);
  imm_op(3'b100, 5'd3, 5'd1, ic);                 // xori
  imm_op(3'b110, 5'd4, 5'd2, 12'h0f0);            // ori
  imm_op(3'b111, 5'd5, 5'd1, 12'hff0);            // andi with -16.
  imm_op(3'b010, 5'd6, 5'd2, 12'h001);            // slti
  imm_op(3'b011, 5'd7, 5'd2, 12'h001);            // sltiu
  imm_op(3'b001, 5'd8, 5'd1, 12'h005);            // slli
  imm_op(3'b101, 5'd9, 5'd2, 12'h403);            // srai by 3.
  imm_op(3'b101, 5'd10, 5'd2, 12'h003);           // srli by 3.
  upper_imm(5'd11, 20'h12345);
  imm_op(3'b000, 5'd11, 5'd11, 12'h678);

  // ####################
  // R-type and forwarding
  // ####################
  imm_op(3'b000, 5'd15, 5'd0, 12'h007);
  reg_op(3'b000, 1'b0, 5'd12, 5'd11, 5'd15);      // add
  reg_op(3'b000, 1'b1, 5'd13, 5'd12, 5'd11);      // sub
  reg_op(3'b001, 1'b0, 5'd14, 5'd13, 5'd15);      // sll, x15 three back.
  reg_op(3'b101, 1'b0, 5'd16, 5'd14, 5'd15);      // srl
  reg_op(3'b101, 1'b1, 5'd17, 5'd2, 5'd15);       // sra
  reg_op(3'b010, 1'b0, 5'd18, 5'd2, 5'd1);        // slt
  reg_op(3'b011, 1'b0, 5'd19, 5'd2, 5'd1);        // sltu
  reg_op(3'b100, 1'b0, 5'd20, 5'd18, 5'd19);
  reg_op(3'b111, 1'b0, 5'd21, 5'd14, 5'd13);
  reg_op(3'b110, 1'b0, 5'd22, 5'd21, 5'd20);

  // Write-through and x0.
  imm_op(3'b000, 5'd23, 5'd0, 12'h055);
  imm_op(3'b000, 5'd0, 5'd0, 12'h000);
  imm_op(3'b000, 5'd0, 5'd0, 12'h000);
  imm_op(3'b000, 5'd24, 5'd23, 12'h001);
  imm_op(3'b000, 5'd0, 5'd1, 12'h123);
  reg_op(3'b000, 1'b0, 5'd25, 5'd0, 5'd1);

  // ####################
  // Data memory
  // ####################
  imm_op(3'b000, 5'd26, 5'd0, 12'h040);
  store_word(5'd22, 5'd26, 12'h000);
  store_word(5'd12, 5'd26, 12'h004);
  imm_op(3'b000, 5'd27, 5'd26, 12'h100);          // Aliases x26 one memory size up.
  load_word(5'd28, 5'd26, 12'h000);
  load_word(5'd29, 5'd27, 12'h004);
  store_word(5'd13, 5'd27, 12'h000);
  load_word(5'd30, 5'd26, 12'h000);
  reg_op(3'b000, 1'b0, 5'd31, 5'd28, 5'd29);

  // mscratch, back to back.
  csr_access(3'b001, 5'd3, 5'd11);                // csrrw
  csr_access(3'b010, 5'd4, 5'd15);                // csrrs
  csr_access(3'b011, 5'd6, 5'd23);                // csrrc
  csr_access(3'b010, 5'd7, 5'd0);
  csr_access(3'b001, 5'd0, 5'd1);
  csr_access(3'b010, 5'd8, 5'd0);
endtask

`endif

//--- tb/tb_core.sv
`timescale 1ns/1ps

module tb_core;

  localparam int          MAX_PROG   = 64;
  localparam int          DMEM_DEPTH = 64;
  localparam logic [31:0] RESET_PC   = 32'h0000_0000;
  localparam logic [31:0] NOP        = 32'h0000_0013; // addi x0, x0, 0

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  // ####################
  // Program table
  // ####################
  logic [31:0] prog_inst [MAX_PROG];
  logic [4:0]  prog_rd   [MAX_PROG]; // Zero means no writeback.
  logic [31:0] prog_val  [MAX_PROG];
  int          prog_len;
  logic        prog_loaded;
  logic        in_range;

  // Architectural state tracked while the table is built.
  logic [31:0] xr        [32];
  logic [31:0] dmem_ref  [DMEM_DEPTH];
  logic [31:0] mscratch_ref;
  integer      seed;

  logic [31:0] fetch_exp; // Next fetch address.

  int          errors;
  int          checks;

  core_top #(
    .RESET_PC  (RESET_PC),
    .DMEM_DEPTH(DMEM_DEPTH)
  ) u_core_top (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .imem_addr_o(imem_addr),
    .imem_data_i(imem_data),
    .wb_valid_o (wb_valid),
    .wb_rd_o    (wb_rd),
    .wb_data_o  (wb_data)
  );

  `include "tb_core_prog.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Instruction memory answers the fetch address directly.
  always_comb begin
    in_range  = imem_addr[31:2] < 30'(prog_len);
    imem_data = in_range ? prog_inst[imem_addr[7:2]] : NOP;
  end

  task automatic wait_writeback();
    do begin
      @(negedge clk);
      assert (!(wb_valid && wb_rd == 5'd0)) else begin
        errors++;
        $display("[ERROR] %0t ns: writeback reported for x0", $time);
      end
    end while (!wb_valid);
  endtask

  task automatic check_writeback(input logic [4:0] rd, input logic [31:0] val);
    checks++;
    assert (wb_rd == rd && wb_data == val) else begin
      errors++;
      $display("[ERROR] %0t ns: writeback x%0d = %08h, expected x%0d = %08h",
               $time, wb_rd, wb_data, rd, val);
    end
  endtask

  // Fetch address starts at RESET_PC and steps by one word.
  initial begin
    fetch_exp = RESET_PC;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      assert (imem_addr == fetch_exp) else begin
        errors++;
        $display("[ERROR] %0t ns: fetch address %08h, expected %08h",
                 $time, imem_addr, fetch_exp);
      end
      fetch_exp = fetch_exp + 32'd4;
    end
  end

  // ####################
  // Main sequence
  // ####################
  initial begin
    rst_n       = 1'b0;
    prog_loaded = 1'b0;
    errors      = 0;
    checks      = 0;
    build_program();
    prog_loaded = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < prog_len; i++) begin
      if (prog_rd[i[5:0]] != 5'd0) begin
        wait_writeback();
        check_writeback(prog_rd[i[5:0]], prog_val[i[5:0]]);
      end
    end

    // Only nops follow, so the port must stay quiet.
    repeat (6) begin
      @(negedge clk);
      assert (!wb_valid) else begin
        errors++;
        $display("[ERROR] %0t ns: extra writeback of x%0d after the program", $time, wb_rd);
      end
    end

    $display("Writebacks checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    wait (prog_loaded);
    #((prog_len + 20) * 10);
    $display("Timeout: writebacks stopped after %0d of the expected results", checks);
    $display("TEST FAILED");
    $finish;
  end

endmodule
